// ==== common/regfile_params.svh ====
`ifndef REGFILE_PARAMS_SVH
`define REGFILE_PARAMS_SVH

// architectural registers seen by the mapper
`define ARCHFILE_SIZE 32

// physical registers behind the rename tables
`define PHYSFILE_SIZE 64

// data width of one register
`define REG_SIZE 32

// index widths
`define ARCH_IDX_W $clog2(`ARCHFILE_SIZE)
`define PHYS_IDX_W $clog2(`PHYSFILE_SIZE)

// free counter must hold PHYSFILE_SIZE itself
`define FREE_CNT_W $clog2(`PHYSFILE_SIZE + 1)

`endif

// ==== common/regfile_types_pkg.sv ====
`include "regfile_params.svh"

package regfile_types_pkg;

    // architectural register number
    typedef logic [`ARCH_IDX_W-1:0] arch_idx_t;

    // physical register number
    typedef logic [`PHYS_IDX_W-1:0] phys_idx_t;

    // register contents
    typedef logic [`REG_SIZE-1:0] reg_val_t;

    // free register count, 0 up to PHYSFILE_SIZE
    typedef logic [`FREE_CNT_W-1:0] free_cnt_t;

    // per physical register flag vector
    typedef logic [`PHYSFILE_SIZE-1:0] phys_vec_t;

endpackage

// ==== common/regfile_update_pkg.sv ====
`include "regfile_params.svh"

package regfile_update_pkg;

    // retirement from the ROB
    // arch now maps to nonspec_phys in the committed table,
    // free_phys is the previous committed mapping going back to the pool
    typedef struct packed {
        logic                          valid;
        regfile_types_pkg::arch_idx_t  arch;
        regfile_types_pkg::phys_idx_t  nonspec_phys;
        regfile_types_pkg::phys_idx_t  free_phys;
    } rob_commit_t;

    // result ring broadcast
    typedef struct packed {
        logic                          valid;
        regfile_types_pkg::phys_idx_t  phys;
        regfile_types_pkg::reg_val_t   val;
    } ring_write_t;

endpackage

// ==== common/rename_if.sv ====
`timescale 1ns/1ps

interface rename_if;
    import regfile_types_pkg::*;

    // rename accepted this cycle
    logic      alloc;

    // lowest free register, valid while none_free is low
    phys_idx_t new_phys;
    logic      none_free;

    // speculative map lookups for the incoming uop
    phys_idx_t src1_phys;
    phys_idx_t src2_phys;
    phys_idx_t old_phys;

    modport map (
        output alloc,
        output src1_phys,
        output src2_phys,
        output old_phys,
        input  new_phys,
        input  none_free
    );

    modport phys (
        input  alloc,
        input  src1_phys,
        input  src2_phys,
        input  old_phys,
        output new_phys,
        output none_free
    );

endinterface

// ==== arch_map/arch_map.sv ====
`timescale 1ns/1ps
`include "regfile_params.svh"

module arch_map (
    input  logic                           clk,
    input  logic                           rst,
    input  regfile_types_pkg::arch_idx_t   arch_rd1,
    input  regfile_types_pkg::arch_idx_t   arch_rd2,
    input  regfile_types_pkg::arch_idx_t   arch_wr,
    input  logic                           uop_update,
    input  logic                           rollback,
    input  regfile_update_pkg::rob_commit_t commit,
    rename_if.map                          ren
);
    import regfile_types_pkg::*;

    // speculative table, updated at rename
    phys_idx_t spec_map [`ARCHFILE_SIZE];
    // committed table, updated at retirement
    phys_idx_t comm_map [`ARCHFILE_SIZE];

    // a uop is dropped with no free register or during rollback
    assign ren.alloc = uop_update && !ren.none_free && !rollback;

    // sources read the mapping before this uop's own write
    assign ren.src1_phys = spec_map[arch_rd1];
    assign ren.src2_phys = spec_map[arch_rd2];
    assign ren.old_phys  = spec_map[arch_wr];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `ARCHFILE_SIZE; i++) begin
                spec_map[i] <= phys_idx_t'(i);
            end
        end else if (rollback) begin
            // committed table as it stood before this edge
            spec_map <= comm_map;
        end else if (ren.alloc) begin
            spec_map[arch_wr] <= ren.new_phys;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `ARCHFILE_SIZE; i++) begin
                comm_map[i] <= phys_idx_t'(i);
            end
        end else if (commit.valid) begin
            comm_map[commit.arch] <= commit.nonspec_phys;
        end
    end

endmodule

// ==== phys_file/free_list.sv ====
`timescale 1ns/1ps
`include "regfile_params.svh"

module free_list (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            rollback,
    input  regfile_update_pkg::rob_commit_t commit,
    rename_if.phys                          ren
);
    import regfile_types_pkg::*;

    phys_vec_t free_vec;
    phys_vec_t comm_vec;
    free_cnt_t free_cnt;
    phys_idx_t pick;

    function automatic free_cnt_t count_ones(input phys_vec_t vec);
        free_cnt_t n;
        n = '0;
        for (int i = 0; i < `PHYSFILE_SIZE; i++) begin
            n = n + free_cnt_t'(vec[i]);
        end
        return n;
    endfunction

    // lowest set bit wins
    always_comb begin
        pick = '0;
        for (int i = `PHYSFILE_SIZE - 1; i >= 0; i--) begin
            if (free_vec[i]) begin
                pick = phys_idx_t'(i);
            end
        end
    end

    assign ren.new_phys  = pick;
    assign ren.none_free = (free_cnt == '0);

    // free vector and count
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `PHYSFILE_SIZE; i++) begin
                free_vec[i] <= (i >= `ARCHFILE_SIZE);
            end
            free_cnt <= free_cnt_t'(`PHYSFILE_SIZE - `ARCHFILE_SIZE);
        end else if (rollback) begin
            // everything not committed comes back
            free_vec <= ~comm_vec;
            free_cnt <= count_ones(~comm_vec);
        end else begin
            if (ren.alloc) begin
                free_vec[ren.new_phys] <= 1'b0;
            end
            if (commit.valid) begin
                free_vec[commit.free_phys] <= 1'b1;
            end
            free_cnt <= free_cnt + free_cnt_t'(commit.valid) - free_cnt_t'(ren.alloc);
        end
    end

    // committed vector tracks the committed map contents
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `PHYSFILE_SIZE; i++) begin
                comm_vec[i] <= (i < `ARCHFILE_SIZE);
            end
        end else if (commit.valid) begin
            comm_vec[commit.free_phys]    <= 1'b0;
            comm_vec[commit.nonspec_phys] <= 1'b1;
        end
    end

endmodule

// ==== phys_file/phys_file.sv ====
`timescale 1ns/1ps
`include "regfile_params.svh"

module phys_file (
    input  logic                            clk,
    input  logic                            rst,
    input  regfile_types_pkg::phys_idx_t    rd1_phys,
    input  regfile_types_pkg::phys_idx_t    rd2_phys,
    input  regfile_update_pkg::ring_write_t ring,
    rename_if.phys                          ren,
    output regfile_types_pkg::reg_val_t     rd1_val,
    output regfile_types_pkg::reg_val_t     rd2_val,
    output logic                            rd1_rdy,
    output logic                            rd2_rdy
);
    import regfile_types_pkg::*;

    reg_val_t  vals [`PHYSFILE_SIZE];
    phys_vec_t rdy_vec;

    // values, architectural state starts at zero
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `PHYSFILE_SIZE; i++) begin
                vals[i] <= '0;
            end
        end else if (ring.valid) begin
            vals[ring.phys] <= ring.val;
        end
    end

    // ready bits
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `PHYSFILE_SIZE; i++) begin
                rdy_vec[i] <= (i < `ARCHFILE_SIZE);
            end
        end else begin
            // fresh destination waits for its result
            if (ren.alloc) begin
                rdy_vec[ren.new_phys] <= 1'b0;
            end
            if (ring.valid) begin
                rdy_vec[ring.phys] <= 1'b1;
            end
        end
    end

    // read ports, no bypass of this cycle's ring write
    always_ff @(posedge clk) begin
        if (rst) begin
            rd1_val <= '0;
            rd2_val <= '0;
            rd1_rdy <= 1'b0;
            rd2_rdy <= 1'b0;
        end else begin
            rd1_val <= vals[rd1_phys];
            rd2_val <= vals[rd2_phys];
            rd1_rdy <= rdy_vec[rd1_phys];
            rd2_rdy <= rdy_vec[rd2_phys];
        end
    end

endmodule

// ==== verilog/regfile_top.sv ====
`timescale 1ns/1ps

module regfile_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          uop_update,
    input  regfile_types_pkg::arch_idx_t  arch_rd1,
    input  regfile_types_pkg::arch_idx_t  arch_rd2,
    input  regfile_types_pkg::arch_idx_t  arch_wr,
    input  logic                          ring_update,
    input  regfile_types_pkg::phys_idx_t  phys_ring,
    input  regfile_types_pkg::reg_val_t   phys_ring_val,
    input  logic                          rob_update,
    input  regfile_types_pkg::arch_idx_t  arch_rob_update,
    input  regfile_types_pkg::phys_idx_t  arch_rob_nonspec_phys,
    input  regfile_types_pkg::phys_idx_t  phys_rob_free,
    input  logic                          rollback,
    output logic                          phys_rd1_rdy,
    output logic                          phys_rd2_rdy,
    output regfile_types_pkg::phys_idx_t  phys_rd1,
    output regfile_types_pkg::phys_idx_t  phys_rd2,
    output regfile_types_pkg::reg_val_t   phys_rd1_val,
    output regfile_types_pkg::reg_val_t   phys_rd2_val,
    output regfile_types_pkg::phys_idx_t  phys_wr,
    output regfile_types_pkg::phys_idx_t  oldphys_wr,
    output logic                          none_free
);
    import regfile_types_pkg::*;
    import regfile_update_pkg::*;

    rob_commit_t commit;
    ring_write_t ring;

    // stage 1 indices, held when no uop is accepted
    phys_idx_t s1_rd1;
    phys_idx_t s1_rd2;
    phys_idx_t s1_wr;
    phys_idx_t s1_old;

    rename_if ren ();

    assign commit.valid        = rob_update;
    assign commit.arch         = arch_rob_update;
    assign commit.nonspec_phys = arch_rob_nonspec_phys;
    assign commit.free_phys    = phys_rob_free;

    assign ring.valid = ring_update;
    assign ring.phys  = phys_ring;
    assign ring.val   = phys_ring_val;

    assign none_free = ren.none_free;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_rd1 <= '0;
            s1_rd2 <= '0;
            s1_wr  <= '0;
            s1_old <= '0;
        end else if (ren.alloc) begin
            s1_rd1 <= ren.src1_phys;
            s1_rd2 <= ren.src2_phys;
            s1_wr  <= ren.new_phys;
            s1_old <= ren.old_phys;
        end
    end

    // stage 2, lines up with the phys_file read registers
    always_ff @(posedge clk) begin
        if (rst) begin
            phys_rd1   <= '0;
            phys_rd2   <= '0;
            phys_wr    <= '0;
            oldphys_wr <= '0;
        end else begin
            phys_rd1   <= s1_rd1;
            phys_rd2   <= s1_rd2;
            phys_wr    <= s1_wr;
            oldphys_wr <= s1_old;
        end
    end

    arch_map u_arch_map (
        .clk        (clk),
        .rst        (rst),
        .arch_rd1   (arch_rd1),
        .arch_rd2   (arch_rd2),
        .arch_wr    (arch_wr),
        .uop_update (uop_update),
        .rollback   (rollback),
        .commit     (commit),
        .ren        (ren.map)
    );

    free_list u_free_list (
        .clk      (clk),
        .rst      (rst),
        .rollback (rollback),
        .commit   (commit),
        .ren      (ren.phys)
    );

    phys_file u_phys_file (
        .clk      (clk),
        .rst      (rst),
        .rd1_phys (s1_rd1),
        .rd2_phys (s1_rd2),
        .ring     (ring),
        .ren      (ren.phys),
        .rd1_val  (phys_rd1_val),
        .rd2_val  (phys_rd2_val),
        .rd1_rdy  (phys_rd1_rdy),
        .rd2_rdy  (phys_rd2_rdy)
    );

endmodule

// ==== testbench/regfile_tb.sv ====
`timescale 1ns/1ps

module regfile_tb;
    import regfile_types_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int DRIVE_DLY  = 2;
    localparam int MAX_LINES  = 256;
    localparam int NCOLS      = 22;

    logic      clk;
    logic      rst;
    logic      uop_update;
    arch_idx_t arch_rd1;
    arch_idx_t arch_rd2;
    arch_idx_t arch_wr;
    logic      ring_update;
    phys_idx_t phys_ring;
    reg_val_t  phys_ring_val;
    logic      rob_update;
    arch_idx_t arch_rob_update;
    phys_idx_t arch_rob_nonspec_phys;
    phys_idx_t phys_rob_free;
    logic      rollback;
    logic      phys_rd1_rdy;
    logic      phys_rd2_rdy;
    phys_idx_t phys_rd1;
    phys_idx_t phys_rd2;
    reg_val_t  phys_rd1_val;
    reg_val_t  phys_rd2_val;
    phys_idx_t phys_wr;
    phys_idx_t oldphys_wr;
    logic      none_free;

    // one row per golden line with the file's columns
    logic [31:0] gold [MAX_LINES][NCOLS];
    int          n_lines = 0;
    int          errors  = 0;
    int          checks  = 0;
    bit          loaded  = 1'b0;
    int          pending [$];

    // indices of the last accepted uop, all zero out of reset
    phys_idx_t   last_rd1 = '0;
    phys_idx_t   last_rd2 = '0;
    phys_idx_t   last_wr  = '0;
    phys_idx_t   last_old = '0;

    regfile_top u_regfile_top (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_phys(input string name, input phys_idx_t got, input phys_idx_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic check_val(input string name, input reg_val_t got, input reg_val_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0d ns: %s is %0b, expected %0b", $time, name, got, exp);
        end
    endtask

    task automatic load_golden();
        int    fd;
        int    code;
        string text;
        fd = $fopen("testbench/regfile_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open testbench/regfile_golden.txt");
            errors++;
        end else begin
            while (!$feof(fd) && n_lines < MAX_LINES) begin
                code = $fgets(text, fd);
                if (code > 0 && text.len() > 1 && text[0] != "#") begin
                    code = $sscanf(text,
                        "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        gold[n_lines][0], gold[n_lines][1], gold[n_lines][2],
                        gold[n_lines][3], gold[n_lines][4], gold[n_lines][5],
                        gold[n_lines][6], gold[n_lines][7], gold[n_lines][8],
                        gold[n_lines][9], gold[n_lines][10], gold[n_lines][11],
                        gold[n_lines][12], gold[n_lines][13], gold[n_lines][14],
                        gold[n_lines][15], gold[n_lines][16], gold[n_lines][17],
                        gold[n_lines][18], gold[n_lines][19], gold[n_lines][20],
                        gold[n_lines][21]);
                    if (code == NCOLS) begin
                        n_lines++;
                    end else begin
                        $display("golden line after data line %0d is malformed", n_lines);
                        errors++;
                    end
                end
            end
            $fclose(fd);
            if (n_lines == 0) begin
                $display("golden file holds no data lines");
                errors++;
            end
        end
        loaded = 1'b1;
    endtask

    task automatic drive_line(input int n);
        uop_update            = gold[n][0][0];
        arch_rd1              = arch_idx_t'(gold[n][1]);
        arch_rd2              = arch_idx_t'(gold[n][2]);
        arch_wr               = arch_idx_t'(gold[n][3]);
        ring_update           = gold[n][4][0];
        phys_ring             = phys_idx_t'(gold[n][5]);
        phys_ring_val         = reg_val_t'(gold[n][6]);
        rob_update            = gold[n][7][0];
        arch_rob_update       = arch_idx_t'(gold[n][8]);
        arch_rob_nonspec_phys = phys_idx_t'(gold[n][9]);
        phys_rob_free         = phys_idx_t'(gold[n][10]);
        rollback              = gold[n][11][0];
    endtask

    task automatic drive_idle();
        uop_update            = 1'b0;
        arch_rd1              = '0;
        arch_rd2              = '0;
        arch_wr               = '0;
        ring_update           = 1'b0;
        phys_ring             = '0;
        phys_ring_val         = '0;
        rob_update            = 1'b0;
        arch_rob_update       = '0;
        arch_rob_nonspec_phys = '0;
        phys_rob_free         = '0;
        rollback              = 1'b0;
    endtask

    // a dropped or absent uop leaves the index outputs where they were
    task automatic check_outputs(input int n);
        if (gold[n][12][0]) begin
            check_phys("phys_rd1", phys_rd1, phys_idx_t'(gold[n][13]));
            check_phys("phys_rd2", phys_rd2, phys_idx_t'(gold[n][14]));
            check_phys("phys_wr", phys_wr, phys_idx_t'(gold[n][15]));
            check_phys("oldphys_wr", oldphys_wr, phys_idx_t'(gold[n][16]));
            check_val("phys_rd1_val", phys_rd1_val, reg_val_t'(gold[n][17]));
            check_val("phys_rd2_val", phys_rd2_val, reg_val_t'(gold[n][18]));
            check_flag("phys_rd1_rdy", phys_rd1_rdy, gold[n][19][0]);
            check_flag("phys_rd2_rdy", phys_rd2_rdy, gold[n][20][0]);
            last_rd1 = phys_idx_t'(gold[n][13]);
            last_rd2 = phys_idx_t'(gold[n][14]);
            last_wr  = phys_idx_t'(gold[n][15]);
            last_old = phys_idx_t'(gold[n][16]);
        end else begin
            check_phys("phys_rd1", phys_rd1, last_rd1);
            check_phys("phys_rd2", phys_rd2, last_rd2);
            check_phys("phys_wr", phys_wr, last_wr);
            check_phys("oldphys_wr", oldphys_wr, last_old);
        end
    endtask

    initial begin
        rst = 1'b1;
        drive_idle();
        load_golden();
        repeat (2) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;
        // two extra slots drain the pipeline
        for (int n = 0; n < n_lines + 2; n++) begin
            if (n >= 2) begin
                check_outputs(pending.pop_front());
            end
            if (n < n_lines) begin
                check_flag("none_free", none_free, gold[n][21][0]);
                drive_line(n);
                pending.push_back(n);
            end else begin
                drive_idle();
            end
            @(posedge clk);
            #DRIVE_DLY;
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (loaded);
        #((n_lines + 10) * CLK_PERIOD);
        $display("timeout: run did not finish within %0d cycles", n_lines + 10);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// ==== testbench/regfile_golden.txt ====
# inputs (hex): uop rd1 rd2 wr ring ring_phys ring_val rob rob_arch rob_phys rob_free rollback
# expected two cycles later: valid rd1 rd2 wr old val1 val2 rdy1 rdy2, last none_free now
1 01 02 03 0 00 00000000 0 00 00 00 0 1 01 02 20 03 00000000 00000000 1 1 0
1 03 04 05 0 00 00000000 0 00 00 00 0 1 20 04 21 05 00000000 00000000 0 1 0
1 05 06 07 1 20 deadbeef 0 00 00 00 0 1 21 06 22 07 00000000 00000000 0 1 0
1 03 00 03 0 00 00000000 0 00 00 00 0 1 20 00 23 20 deadbeef 00000000 1 1 0
1 00 00 08 0 00 00000000 0 00 00 00 0 1 00 00 24 08 00000000 00000000 1 1 0
1 00 00 09 0 00 00000000 0 00 00 00 0 1 00 00 25 09 00000000 00000000 1 1 0
1 00 00 0a 0 00 00000000 0 00 00 00 0 1 00 00 26 0a 00000000 00000000 1 1 0
1 00 00 0b 0 00 00000000 0 00 00 00 0 1 00 00 27 0b 00000000 00000000 1 1 0
1 00 00 0c 0 00 00000000 0 00 00 00 0 1 00 00 28 0c 00000000 00000000 1 1 0
1 00 00 0d 0 00 00000000 0 00 00 00 0 1 00 00 29 0d 00000000 00000000 1 1 0
1 00 00 0e 0 00 00000000 0 00 00 00 0 1 00 00 2a 0e 00000000 00000000 1 1 0
1 00 00 0f 0 00 00000000 0 00 00 00 0 1 00 00 2b 0f 00000000 00000000 1 1 0
1 00 00 10 0 00 00000000 0 00 00 00 0 1 00 00 2c 10 00000000 00000000 1 1 0
1 00 00 11 0 00 00000000 0 00 00 00 0 1 00 00 2d 11 00000000 00000000 1 1 0
1 00 00 12 0 00 00000000 0 00 00 00 0 1 00 00 2e 12 00000000 00000000 1 1 0
1 00 00 13 0 00 00000000 0 00 00 00 0 1 00 00 2f 13 00000000 00000000 1 1 0
1 00 00 14 0 00 00000000 0 00 00 00 0 1 00 00 30 14 00000000 00000000 1 1 0
1 00 00 15 0 00 00000000 0 00 00 00 0 1 00 00 31 15 00000000 00000000 1 1 0
1 00 00 16 0 00 00000000 0 00 00 00 0 1 00 00 32 16 00000000 00000000 1 1 0
1 00 00 17 0 00 00000000 0 00 00 00 0 1 00 00 33 17 00000000 00000000 1 1 0
1 00 00 18 0 00 00000000 0 00 00 00 0 1 00 00 34 18 00000000 00000000 1 1 0
1 00 00 19 0 00 00000000 0 00 00 00 0 1 00 00 35 19 00000000 00000000 1 1 0
1 00 00 1a 0 00 00000000 0 00 00 00 0 1 00 00 36 1a 00000000 00000000 1 1 0
1 00 00 1b 0 00 00000000 0 00 00 00 0 1 00 00 37 1b 00000000 00000000 1 1 0
1 00 00 1c 0 00 00000000 0 00 00 00 0 1 00 00 38 1c 00000000 00000000 1 1 0
1 00 00 1d 0 00 00000000 0 00 00 00 0 1 00 00 39 1d 00000000 00000000 1 1 0
1 00 00 1e 0 00 00000000 0 00 00 00 0 1 00 00 3a 1e 00000000 00000000 1 1 0
1 00 00 1f 0 00 00000000 0 00 00 00 0 1 00 00 3b 1f 00000000 00000000 1 1 0
1 00 00 01 0 00 00000000 0 00 00 00 0 1 00 00 3c 01 00000000 00000000 1 1 0
1 00 00 02 0 00 00000000 0 00 00 00 0 1 00 00 3d 02 00000000 00000000 1 1 0
1 00 00 04 0 00 00000000 0 00 00 00 0 1 00 00 3e 04 00000000 00000000 1 1 0
1 00 00 06 0 00 00000000 0 00 00 00 0 1 00 00 3f 06 00000000 00000000 1 1 0
1 01 03 09 0 00 00000000 0 00 00 00 0 0 00 00 00 00 00000000 00000000 0 0 1
0 00 00 00 0 00 00000000 1 03 20 03 0 0 00 00 00 00 00000000 00000000 0 0 1
1 03 09 0a 1 23 12345678 0 00 00 00 0 1 23 25 03 26 12345678 00000000 1 0 0
0 00 00 00 0 00 00000000 0 00 00 00 1 0 00 00 00 00 00000000 00000000 0 0 1
1 03 05 05 0 00 00000000 0 00 00 00 0 1 20 05 03 05 deadbeef 00000000 1 1 0
1 05 0a 07 0 00 00000000 0 00 00 00 0 1 03 0a 21 07 00000000 00000000 0 1 0

// ==== regfile_rename.f ====
+incdir+common
common/regfile_types_pkg.sv
common/regfile_update_pkg.sv
common/rename_if.sv
arch_map/arch_map.sv
phys_file/free_list.sv
phys_file/phys_file.sv
verilog/regfile_top.sv
testbench/regfile_tb.sv
